// ==== logic/vtl_pkg.sv ====
// shared timing constants, port numbers, palette and bus structs for the video chip
// other files reach these through vtl_pkg:: scoped names
package vtl_pkg;

	// horizontal timing in F14M clocks
	localparam int HSW          = 66;   // hsync width
	localparam int HBP          = 70;   // back porch
	localparam int H_VISIBLE    = 798;
	localparam int HFP          = 10;   // front porch
	localparam int LEFT_BORDER  = 72;
	localparam int ACTIVE_WIDTH = 640;

	// vertical timing in lines
	localparam int V_LINES       = 313;
	localparam int TOP_BORDER    = 65;
	localparam int ACTIVE_HEIGHT = 192;
	localparam int VSYNC_LINES   = 4;
	localparam int VBLANK_LINES  = 2;

	// z80 i/o ports
	localparam logic [7:0] PORT_BANK0       = 8'h40;  // 0x40..0x43
	localparam logic [7:0] PORT_VDC_MODE    = 8'h44;
	localparam logic [7:0] PORT_VDC_COLORS  = 8'h45;
	localparam logic [7:0] PORT_JOY0_DIR    = 8'h2b;
	localparam logic [7:0] PORT_JOY0_FIRE   = 8'h27;
	localparam logic [7:0] PORT_JOY1_DIR    = 8'h2e;
	localparam logic [7:0] PORT_JOY1_FIRE   = 8'h2d;
	localparam logic [7:0] PORT_IMG_SIZE0   = 8'ha0;  // four bytes, lsb first
	localparam logic [7:0] PORT_IMG_MOUNTED = 8'ha4;

	// mapped i/o window inside bank 2
	localparam logic [3:0]  MAPPED_BANK = 4'd2;
	localparam logic [13:0] MAPPED_LO   = 14'h2800;
	localparam logic [13:0] MAPPED_HI   = 14'h2fff;

	typedef logic [3:0] color_t;
	typedef logic [15:0][11:0] palette_t;

	// 4 bits per channel, entry 15 listed first
	localparam palette_t PALETTE = {
		12'hfff, 12'hcf0, 12'hf9f, 12'hf45,  // white, br yellow, br magenta, br red
		12'h4ff, 12'h0f0, 12'h88f, 12'h555,  // br cyan, br green, br blue, dark grey
		12'h999, 12'h780, 12'hf0f, 12'ha00,  // grey, yellow, magenta, red
		12'h08f, 12'h080, 12'h00f, 12'h000   // cyan, green, blue, black
	};

	// cpu pins after inversion, all active high
	typedef struct packed {
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  dout;
	} cpu_bus_t;

	// one-clock strobes from the beat decoder
	typedef struct packed {
		logic mem_write;  // phase 1
		logic mem_latch;  // phase 2, memory read
		logic write_end;  // phase 2
		logic io_write;
		logic io_read;
	} cpu_access_t;

	typedef struct packed {
		logic   graphics_on;
		logic   page_7;   // video ram in page 7, else page 3
		color_t border;
		color_t fg;
		color_t bg;
	} vdc_cfg_t;

endpackage

// ==== logic/raster_timing.sv ====
// line and frame counters with negative syncs and the blank and border regions
// hcnt[2:0] doubles as the bus slot counter
`timescale 1ns/1ps

module raster_timing #(
	parameter int H_TOTAL = 944,
	parameter int V_LINES = 313
) (
	input  logic       F14M,
	input  logic       RESET,
	output logic [9:0] hcnt,
	output logic [9:0] vcnt,
	output logic [2:0] slot,
	output logic       hsync,
	output logic       vsync,
	output logic       in_blank,
	output logic       in_border
);

	localparam int H_START = vtl_pkg::HSW + vtl_pkg::HBP;        // first visible clock
	localparam int H_END   = H_START + vtl_pkg::H_VISIBLE;
	localparam int X_START = H_START + vtl_pkg::LEFT_BORDER;     // first active clock
	localparam int X_END   = X_START + vtl_pkg::ACTIVE_WIDTH;
	localparam int Y_END   = vtl_pkg::TOP_BORDER + vtl_pkg::ACTIVE_HEIGHT;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == 10'(H_TOTAL - 1)) begin
			hcnt <= '0;
			if (vcnt == 10'(V_LINES - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 10'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign slot = hcnt[2:0];

	assign hsync = !(hcnt < 10'(vtl_pkg::HSW));          // low during sync
	assign vsync = !(vcnt < 10'(vtl_pkg::VSYNC_LINES));

	assign in_blank = (hcnt < 10'(H_START)) || (hcnt >= 10'(H_END)) ||
		(vcnt < 10'(vtl_pkg::VBLANK_LINES));

	// top and bottom bands plus left and right bands
	assign in_border = (vcnt < 10'(vtl_pkg::TOP_BORDER)) || (vcnt >= 10'(Y_END)) ||
		(hcnt < 10'(X_START)) || (hcnt >= 10'(X_END));

endmodule

// ==== logic/cpu_beat.sv ====
// four-clock z80 beat: CPUENA pulse, skipped beat on a new MREQ,
// and the one-clock access strobes used by the register and SDRAM blocks
`timescale 1ns/1ps

module cpu_beat (
	input  logic                  F14M,
	input  logic                  RESET,
	input  vtl_pkg::cpu_bus_t     bus,
	input  logic [2:0]            slot,
	output logic                  CPUENA,
	output vtl_pkg::cpu_access_t  access
);

	logic [1:0] phase;
	logic       mreq_old;
	logic       skip_beat;

	assign phase = slot[1:0];  // beat repeats twice per slot group

	// phase 3 samples MREQ, phase 0 runs the cpu for one clock
	always_ff @(posedge F14M) begin
		if (RESET) begin
			mreq_old  <= 1'b0;
			skip_beat <= 1'b0;
			CPUENA    <= 1'b0;
		end else begin
			if (phase == 2'd3) begin
				mreq_old  <= bus.mreq;
				skip_beat <= !mreq_old && bus.mreq;  // rising MREQ, give memory a beat
			end
			CPUENA <= (phase == 2'd0) && !skip_beat;
		end
	end

	// strobes stay low for the whole skipped beat
	always_comb begin
		access = '0;
		if (!skip_beat) begin
			if (phase == 2'd1)
				access.mem_write = bus.mreq && bus.wr;
			if (phase == 2'd2) begin
				access.mem_latch = bus.mreq && bus.rd;
				access.write_end = bus.mreq && bus.wr;
				access.io_write  = bus.iorq && bus.wr;
				access.io_read   = bus.iorq && bus.rd;
			end
		end
	end

endmodule

// ==== logic/port_registers.sv ====
// bank registers, video config, mapped i/o latch and the cpu read data mux
// all writes are taken on the strobes from cpu_beat
`timescale 1ns/1ps

module port_registers (
	input  logic                 F14M,
	input  logic                 RESET,
	input  vtl_pkg::cpu_bus_t    bus,
	input  vtl_pkg::cpu_access_t access,
	input  logic [6:0]           KD,
	input  logic                 CASIN,
	input  logic [31:0]          joystick_0,
	input  logic [31:0]          joystick_1,
	input  logic                 img_mounted,
	input  logic [31:0]          img_size,
	input  logic [7:0]           sdram_dout,
	output logic [7:0]           DI,
	output logic                 BUZZER,
	output logic                 CASOUT,
	output vtl_pkg::vdc_cfg_t    cfg,
	output logic [3:0]           bank,
	output logic                 bank_is_ram,
	output logic                 mapped_io
);

	logic [3:0] banks [4];  // one per 16 KB quarter

	// joystick bits are active low on the bus: ---FEWSN
	function automatic logic [7:0] joy_dir(input logic [31:0] joy);
		return {3'b111, ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
	endfunction

	function automatic logic [7:0] joy_fire(input logic [31:0] joy);
		return {3'b111, ~joy[5], 4'b1111};
	endfunction

	assign bank        = banks[bus.addr[15:14]];
	assign bank_is_ram = (bank >= 4'd4) && (bank <= 4'd7);
	assign mapped_io   = (bank == vtl_pkg::MAPPED_BANK) &&
		(bus.addr[13:0] >= vtl_pkg::MAPPED_LO) && (bus.addr[13:0] <= vtl_pkg::MAPPED_HI);

	always_ff @(posedge F14M) begin
		if (RESET) begin
			foreach (banks[i])
				banks[i] <= '0;
			cfg    <= '0;
			BUZZER <= 1'b0;
			CASOUT <= 1'b0;
		end else begin
			if (access.mem_write && mapped_io) begin
				cfg.graphics_on <= bus.dout[3];
				CASOUT          <= bus.dout[2];
				BUZZER          <= bus.dout[0];
			end
			if (access.io_write) begin
				if (bus.addr[7:2] == vtl_pkg::PORT_BANK0[7:2])
					banks[bus.addr[1:0]] <= bus.dout[3:0];
				else if (bus.addr[7:0] == vtl_pkg::PORT_VDC_MODE) begin
					cfg.page_7 <= ~bus.dout[3];  // 0 selects page 7
					cfg.border <= bus.dout[7:4];
				end else if (bus.addr[7:0] == vtl_pkg::PORT_VDC_COLORS) begin
					cfg.fg <= bus.dout[7:4];
					cfg.bg <= bus.dout[3:0];
				end
			end
		end
	end

	// DI holds its value between reads
	always_ff @(posedge F14M) begin
		if (RESET)
			DI <= '0;
		else if (access.mem_latch)
			DI <= mapped_io ? {CASIN, KD} : sdram_dout;  // keyboard rows in the window
		else if (access.io_read) begin
			case (bus.addr[7:0])
				vtl_pkg::PORT_JOY0_DIR:          DI <= joy_dir(joystick_0);
				vtl_pkg::PORT_JOY0_FIRE:         DI <= joy_fire(joystick_0);
				vtl_pkg::PORT_JOY1_DIR:          DI <= joy_dir(joystick_1);
				vtl_pkg::PORT_JOY1_FIRE:         DI <= joy_fire(joystick_1);
				vtl_pkg::PORT_IMG_SIZE0:         DI <= img_size[7:0];
				vtl_pkg::PORT_IMG_SIZE0 + 8'd1:  DI <= img_size[15:8];
				vtl_pkg::PORT_IMG_SIZE0 + 8'd2:  DI <= img_size[23:16];
				vtl_pkg::PORT_IMG_SIZE0 + 8'd3:  DI <= img_size[31:24];
				vtl_pkg::PORT_IMG_MOUNTED:       DI <= {7'b0, img_mounted};
				default:                         DI <= {DI[7:1], 1'b1};  // unused port
			endcase
		end
	end

endmodule

// ==== logic/sdram_slots.sv ====
// shares the SDRAM port between the video fetch in slot 7 and the cpu in beat phase 1
// address is page or bank on top of a 14-bit offset
`timescale 1ns/1ps

module sdram_slots (
	input  logic                 F14M,
	input  logic                 RESET,
	input  logic [2:0]           slot,
	input  vtl_pkg::cpu_access_t access,
	input  vtl_pkg::vdc_cfg_t    cfg,
	input  logic [3:0]           bank,
	input  logic                 bank_is_ram,
	input  logic                 mapped_io,
	input  vtl_pkg::cpu_bus_t    bus,
	input  logic [13:0]          video_offset,
	output logic [24:0]          sdram_addr,
	output logic [7:0]           sdram_din,
	output logic                 sdram_rd,
	output logic                 sdram_wr
);

	logic [24:0] video_addr;
	logic [24:0] cpu_addr;

	assign video_addr = {7'd0, (cfg.page_7 ? 4'h7 : 4'h3), video_offset};
	assign cpu_addr   = {7'd0, bank, bus.addr[13:0]};

	always_ff @(posedge F14M) begin
		if (slot == 3'd7)
			sdram_addr <= video_addr;
		else if (slot[1:0] == 2'd1)  // cpu phase 1, slots 1 and 5
			sdram_addr <= cpu_addr;
		if (access.mem_write)
			sdram_din <= bus.dout;
	end

	always_ff @(posedge F14M) begin
		if (RESET) begin
			sdram_rd <= 1'b0;
			sdram_wr <= 1'b0;
		end else begin
			if (slot == 3'd3)
				sdram_rd <= 1'b0;  // refresh gap
			else if (slot == 3'd7 || slot == 3'd4 || slot[1:0] == 2'd1)
				sdram_rd <= 1'b1;
			if (access.mem_write && !mapped_io)
				sdram_wr <= bank_is_ram;  // rom banks ignore writes
			else if (access.write_end)
				sdram_wr <= 1'b0;
		end
	end

endmodule

// ==== logic/gr5_pixel_out.sv ====
// GR5 640x192 mono pixel path: fetch address, byte latch, shifter and palette
// rgb lags the counters by two clocks
`timescale 1ns/1ps

module gr5_pixel_out (
	input  logic              F14M,
	input  logic              RESET,
	input  logic [9:0]        hcnt,
	input  logic [9:0]        vcnt,
	input  logic              in_blank,
	input  logic              in_border,
	input  vtl_pkg::vdc_cfg_t cfg,
	input  logic [7:0]        sdram_dout,
	output logic [13:0]       video_offset,
	output logic [5:0]        r,
	output logic [5:0]        g,
	output logic [5:0]        b
);

	localparam int X_START    = vtl_pkg::HSW + vtl_pkg::HBP + vtl_pkg::LEFT_BORDER;
	localparam int FETCH_LEAD = 16;  // address runs two bytes ahead of the beam

	logic [9:0]      xfetch;
	logic [7:0]      ycnt;
	logic [13:0]     row_base;
	logic [7:0]      ram_data;
	logic [7:0]      shifter;
	vtl_pkg::color_t pixel;
	logic [11:0]     rgb;

	assign xfetch = hcnt - 10'(X_START - FETCH_LEAD);
	assign ycnt   = 8'(vcnt - 10'(vtl_pkg::TOP_BORDER));

	// scrambled row layout, y7:y6 appear twice so the row step is 80 bytes
	assign row_base = {ycnt[2:0], ycnt[5:3], ycnt[7:6], ycnt[7:6], 4'b0000};
	assign video_offset = row_base + 14'(xfetch[9:3]);

	// X_START is a multiple of 8, so hcnt[2:0] tracks the byte phase
	always_ff @(posedge F14M) begin
		if (hcnt[2:0] == 3'd1)
			ram_data <= sdram_dout;  // video slot data
		if (hcnt[2:0] == 3'd7)
			shifter <= ram_data;
		else if (!in_blank && !in_border)
			shifter <= shifter >> 1;  // lsb is leftmost pixel
	end

	always_ff @(posedge F14M) begin
		if (RESET) begin
			pixel <= '0;
			rgb   <= '0;
		end else begin
			if (in_blank)
				pixel <= '0;
			else if (in_border)
				pixel <= cfg.border;
			else if (cfg.graphics_on && shifter[0])
				pixel <= cfg.fg;
			else
				pixel <= cfg.bg;  // also the whole area with graphics off
			rgb <= vtl_pkg::PALETTE[pixel];
		end
	end

	assign r = {rgb[11:8], 2'b00};
	assign g = {rgb[7:4], 2'b00};
	assign b = {rgb[3:0], 2'b00};

endmodule

// ==== logic/vtl_video_chip.sv ====
// Laser 500 video and bus chip top level
// inverts the cpu control pins once and wires the timing, bus and pixel blocks
`timescale 1ns/1ps

module vtl_video_chip #(
	parameter int H_TOTAL = vtl_pkg::HSW + vtl_pkg::HBP + vtl_pkg::H_VISIBLE + vtl_pkg::HFP,
	parameter int V_LINES = vtl_pkg::V_LINES
) (
	input  logic        F14M,
	input  logic        RESET,
	output logic        CPUENA,
	input  logic        MREQ_n,
	input  logic        IORQ_n,
	input  logic        RD_n,
	input  logic        WR_n,
	input  logic [15:0] A,
	input  logic [7:0]  DO,
	output logic [7:0]  DI,
	input  logic [6:0]  KD,
	input  logic        CASIN,
	input  logic [31:0] joystick_0,
	input  logic [31:0] joystick_1,
	output logic [24:0] sdram_addr,
	input  logic [7:0]  sdram_dout,
	output logic [7:0]  sdram_din,
	output logic        sdram_wr,
	output logic        sdram_rd,
	output logic        hsync,
	output logic        vsync,
	output logic [5:0]  r,
	output logic [5:0]  g,
	output logic [5:0]  b,
	output logic        BUZZER,
	output logic        CASOUT,
	input  logic        img_mounted,
	input  logic [31:0] img_size
);

	logic [9:0]           hcnt;
	logic [9:0]           vcnt;
	logic [2:0]           slot;
	logic                 in_blank;
	logic                 in_border;
	vtl_pkg::cpu_bus_t    bus;
	vtl_pkg::cpu_access_t access;
	vtl_pkg::vdc_cfg_t    cfg;
	logic [3:0]           bank;
	logic                 bank_is_ram;
	logic                 mapped_io;
	logic [13:0]          video_offset;

	assign bus.mreq = ~MREQ_n;
	assign bus.iorq = ~IORQ_n;
	assign bus.rd   = ~RD_n;
	assign bus.wr   = ~WR_n;
	assign bus.addr = A;
	assign bus.dout = DO;

	raster_timing #(
		.H_TOTAL(H_TOTAL),
		.V_LINES(V_LINES)
	) i_raster_timing (
		.F14M(F14M), .RESET(RESET), .hcnt(hcnt), .vcnt(vcnt), .slot(slot),
		.hsync(hsync), .vsync(vsync), .in_blank(in_blank), .in_border(in_border)
	);

	cpu_beat i_cpu_beat (
		.F14M(F14M), .RESET(RESET), .bus(bus), .slot(slot), .CPUENA(CPUENA), .access(access)
	);

	port_registers i_port_registers (
		.F14M(F14M), .RESET(RESET), .bus(bus), .access(access), .KD(KD), .CASIN(CASIN),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .img_mounted(img_mounted),
		.img_size(img_size), .sdram_dout(sdram_dout), .DI(DI), .BUZZER(BUZZER),
		.CASOUT(CASOUT), .cfg(cfg), .bank(bank), .bank_is_ram(bank_is_ram),
		.mapped_io(mapped_io)
	);

	sdram_slots i_sdram_slots (
		.F14M(F14M), .RESET(RESET), .slot(slot), .access(access), .cfg(cfg), .bank(bank),
		.bank_is_ram(bank_is_ram), .mapped_io(mapped_io), .bus(bus),
		.video_offset(video_offset), .sdram_addr(sdram_addr), .sdram_din(sdram_din),
		.sdram_rd(sdram_rd), .sdram_wr(sdram_wr)
	);

	gr5_pixel_out i_gr5_pixel_out (
		.F14M(F14M), .RESET(RESET), .hcnt(hcnt), .vcnt(vcnt), .in_blank(in_blank),
		.in_border(in_border), .cfg(cfg), .sdram_dout(sdram_dout),
		.video_offset(video_offset), .r(r), .g(g), .b(b)
	);

endmodule

// ==== sim/tb_vtl.sv ====
// testbench for the video chip with an SDRAM model, z80 bus cycles and checks on sync,
// banking, mapped i/o, port reads and GR5 pixels; compile with sim.f and run tb_vtl
`timescale 1ns/1ps

module tb_vtl;

	localparam int H_TOTAL     = vtl_pkg::HSW + vtl_pkg::HBP + vtl_pkg::H_VISIBLE + vtl_pkg::HFP;
	localparam int V_LINES     = vtl_pkg::V_LINES;
	localparam int FRAME       = H_TOTAL * V_LINES;
	localparam int WATCHDOG    = 3 * FRAME + 2000;  // in clocks
	localparam int DRIVE_DELAY = 5;
	localparam logic [3:0] BORDER = 4'd4;
	localparam logic [3:0] FG     = 4'd14;
	localparam logic [3:0] BG     = 4'd1;

	logic        F14M = 1'b0;
	logic        RESET;
	logic        CPUENA;
	logic        MREQ_n, IORQ_n, RD_n, WR_n;
	logic [15:0] A;
	logic [7:0]  DO, DI;
	logic [6:0]  KD;
	logic        CASIN;
	logic [31:0] joystick_0, joystick_1, img_size;
	logic        img_mounted;
	logic [24:0] sdram_addr;
	logic [7:0]  sdram_dout, sdram_din;
	logic        sdram_wr, sdram_rd;
	logic        hsync, vsync;
	logic [5:0]  r, g, b;
	logic        BUZZER, CASOUT;

	logic [7:0]  ram_model [65536];
	int          pos_h;  // expected hcnt and vcnt
	int          pos_v;
	integer      seed;
	int          ena_count;
	logic        wr_seen;
	logic [24:0] wr_addr;

	always #50 F14M = ~F14M;

	vtl_video_chip #(
		.H_TOTAL(H_TOTAL),
		.V_LINES(V_LINES)
	) i_dut (
		.F14M(F14M), .RESET(RESET), .CPUENA(CPUENA), .MREQ_n(MREQ_n), .IORQ_n(IORQ_n),
		.RD_n(RD_n), .WR_n(WR_n), .A(A), .DO(DO), .DI(DI), .KD(KD), .CASIN(CASIN),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .sdram_addr(sdram_addr),
		.sdram_dout(sdram_dout), .sdram_din(sdram_din), .sdram_wr(sdram_wr),
		.sdram_rd(sdram_rd), .hsync(hsync), .vsync(vsync), .r(r), .g(g), .b(b),
		.BUZZER(BUZZER), .CASOUT(CASOUT), .img_mounted(img_mounted), .img_size(img_size)
	);

	// byte-wide SDRAM with only the low 16 address bits decoded
	assign sdram_dout = ram_model[sdram_addr[15:0]];

	always @(posedge F14M) begin
		if (sdram_wr)
			ram_model[sdram_addr[15:0]] <= sdram_din;
	end

	// beam position as counted from the end of reset
	always @(posedge F14M) begin
		if (RESET) begin
			pos_h <= 0;
			pos_v <= 0;
		end else if (pos_h == H_TOTAL - 1) begin
			pos_h <= 0;
			pos_v <= (pos_v == V_LINES - 1) ? 0 : pos_v + 1;
		end else begin
			pos_h <= pos_h + 1;
		end
	end

	initial begin
		repeat (WATCHDOG) @(posedge F14M);
		$display("timeout: the tests did not finish within three frames");
		$display("test failed");
		$fatal(1);
	end

	task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// expected DI after an i/o read
	function automatic logic [7:0] port_read_value(input logic [7:0] port);
		logic [31:0] joy;
		joy = (port == vtl_pkg::PORT_JOY1_DIR || port == vtl_pkg::PORT_JOY1_FIRE) ?
			joystick_1 : joystick_0;
		if (port == vtl_pkg::PORT_JOY0_DIR || port == vtl_pkg::PORT_JOY1_DIR)
			return {3'b111, ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};  // fire e w s n
		if (port == vtl_pkg::PORT_JOY0_FIRE || port == vtl_pkg::PORT_JOY1_FIRE)
			return {3'b111, ~joy[5], 4'b1111};
		if (port >= vtl_pkg::PORT_IMG_SIZE0 && port < vtl_pkg::PORT_IMG_SIZE0 + 8'd4)
			return 8'(img_size >> (8 * (port - vtl_pkg::PORT_IMG_SIZE0)));
		return {7'd0, img_mounted};
	endfunction

	function automatic logic [24:0] cpu_sdram_addr(input logic [3:0] bank,
		input logic [13:0] offset);
		return {7'd0, bank, offset};
	endfunction

	// read strobe is low only in the clock that follows slot 3
	function automatic logic read_strobe_at(input int h);
		return (h % 8) != 4;
	endfunction

	// palette entry widened to 6 bits per channel
	function automatic logic [17:0] palette_rgb(input logic [3:0] color);
		logic [11:0] entry;
		entry = vtl_pkg::PALETTE[color];
		return {entry[11:8], 2'b00, entry[7:4], 2'b00, entry[3:0], 2'b00};
	endfunction

	task automatic wait_until(input int line, input int x);
		do
			@(negedge F14M);
		while (pos_v != line || pos_h != x);
	endtask

	// returns just after the edge that starts beat phase 0
	task automatic align_beat();
		do
			@(negedge F14M);
		while (pos_h % 4 != 3);
		@(posedge F14M);
		#DRIVE_DELAY;
	endtask

	// request held for two beats while CPUENA and the SDRAM write are watched
	task automatic bus_cycle(input logic is_mem, input logic is_write,
		input logic [15:0] addr, input logic [7:0] data);
		align_beat();
		MREQ_n = !is_mem;
		IORQ_n = is_mem;
		RD_n = is_write;
		WR_n = !is_write;
		A = addr;
		DO = data;
		ena_count = 0;
		wr_seen = 1'b0;
		repeat (8) begin
			@(negedge F14M);
			if (CPUENA)
				ena_count++;
			if (sdram_wr) begin
				wr_seen = 1'b1;
				wr_addr = sdram_addr;
			end
		end
		@(posedge F14M);
		#DRIVE_DELAY;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n = 1'b1;
		WR_n = 1'b1;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		bus_cycle(1'b0, 1'b1, {8'h00, port}, data);
		expect_equal(ena_count, 2, "CPUENA pulses in an i/o cycle");
	endtask

	task automatic fill_video(input logic [7:0] value);
		for (int i = 0; i < 16384; i++)
			ram_model[16'hc000 + i] = value;  // page 7 and page 3 alias here
	endtask

	task automatic measure_sync();
		int n;
		int low_clocks;
		int vs_low;
		int falls;
		int last_fall;
		logic hs_prev;
		low_clocks = 0;
		vs_low = 0;
		falls = 0;
		last_fall = 0;
		hs_prev = 1'b1;
		wait_until(0, 0);
		for (n = 0; n < FRAME; n++) begin
			if (!hsync && hs_prev) begin
				if (falls > 0) begin
					expect_equal(n - last_fall, H_TOTAL, "line period in clocks");
					expect_equal(low_clocks, vtl_pkg::HSW, "hsync low clocks per line");
				end
				last_fall = n;
				falls++;
				low_clocks = 0;
			end
			if (!hsync)
				low_clocks++;
			if (!vsync)
				vs_low++;
			hs_prev = hsync;
			@(negedge F14M);
		end
		expect_equal(falls, V_LINES, "hsync pulses per frame");
		expect_equal(vs_low, vtl_pkg::VSYNC_LINES * H_TOTAL, "vsync low clocks per frame");
	endtask

	task automatic check_read_strobe();
		repeat (64) begin
			@(negedge F14M);
			expect_equal(sdram_rd, read_strobe_at(pos_h), "sdram_rd refresh gap");
		end
	endtask

	task automatic exercise_banks();
		logic [3:0]  banks [4];
		logic [13:0] offset;
		logic [7:0]  data;
		logic [7:0]  old;
		logic [15:0] idx;
		logic        is_ram;
		for (int round = 0; round < 2; round++) begin
			for (int q = 0; q < 4; q++) begin
				banks[q] = 4'($random(seed));
				io_write(vtl_pkg::PORT_BANK0 + 8'(q), {4'h0, banks[q]});
			end
			for (int q = 0; q < 4; q++) begin
				offset = 14'($random(seed)) & 14'h27ff;  // stays below the mapped window
				data = 8'($random(seed));
				idx = {banks[q][1:0], offset};
				old = ram_model[idx];
				is_ram = banks[q] >= 4'd4 && banks[q] <= 4'd7;
				bus_cycle(1'b1, 1'b1, {2'(q), offset}, data);
				expect_equal(ena_count, 1, "CPUENA pulses in a memory cycle");
				expect_equal(wr_seen, is_ram, "sdram_wr only for ram banks");
				if (is_ram)
					expect_equal(wr_addr, cpu_sdram_addr(banks[q], offset), "sdram_addr on write");
				expect_equal(ram_model[idx], is_ram ? data : old, "SDRAM byte after write");
				bus_cycle(1'b1, 1'b0, {2'(q), offset}, 8'h00);
				expect_equal(DI, is_ram ? data : old, "DI after memory read");
			end
		end
	endtask

	task automatic probe_mapped_io();
		logic [15:0] addr;
		logic [7:0]  old;
		addr = {2'b00, vtl_pkg::MAPPED_LO};
		io_write(vtl_pkg::PORT_BANK0, 8'h02);  // quarter 0 -> bank 2
		bus_cycle(1'b1, 1'b0, addr, 8'h00);
		expect_equal(DI, {CASIN, KD}, "keyboard read in mapped window");
		old = ram_model[{2'b10, vtl_pkg::MAPPED_LO}];
		bus_cycle(1'b1, 1'b1, addr, 8'h05);
		expect_equal({BUZZER, CASOUT}, 2'b11, "BUZZER and CASOUT set");
		expect_equal(wr_seen, 1'b0, "no sdram write in mapped window");
		bus_cycle(1'b1, 1'b1, addr, 8'h04);
		expect_equal({BUZZER, CASOUT}, 2'b01, "BUZZER cleared, CASOUT kept");
		expect_equal(ram_model[{2'b10, vtl_pkg::MAPPED_LO}], old, "SDRAM under mapped window");
	endtask

	task automatic read_ports();
		logic [7:0] ports [9];
		ports = '{vtl_pkg::PORT_JOY0_DIR, vtl_pkg::PORT_JOY0_FIRE, vtl_pkg::PORT_JOY1_DIR,
			vtl_pkg::PORT_JOY1_FIRE, 8'ha0, 8'ha1, 8'ha2, 8'ha3, vtl_pkg::PORT_IMG_MOUNTED};
		foreach (ports[i]) begin
			bus_cycle(1'b0, 1'b0, {8'h00, ports[i]}, 8'h00);
			expect_equal(DI, port_read_value(ports[i]), $sformatf("DI from port 0x%h", ports[i]));
		end
	endtask

	// rgb seen at the sample point belongs to the counters two clocks earlier
	task automatic inspect_pixels();
		io_write(vtl_pkg::PORT_VDC_MODE, {BORDER, 4'b0000});  // page 7
		io_write(vtl_pkg::PORT_VDC_COLORS, {FG, BG});
		fill_video(8'hff);
		wait_until(100, 528);
		expect_equal({r, g, b}, palette_rgb(BG), "active area with graphics off");
		bus_cycle(1'b1, 1'b1, {2'b00, vtl_pkg::MAPPED_LO}, 8'h08);
		wait_until(150, 528);
		expect_equal({r, g, b}, palette_rgb(FG), "active pixel from 0xff");
		fill_video(8'h00);
		wait_until(200, 528);
		expect_equal({r, g, b}, palette_rgb(BG), "active pixel from 0x00");
		wait_until(220, 170);
		expect_equal({r, g, b}, palette_rgb(BORDER), "left border");
		wait_until(230, 100);
		expect_equal({r, g, b}, palette_rgb(4'd0), "horizontal blank");
	endtask

	initial begin
		seed = 32'hced6554f;
		RESET = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n = 1'b1;
		WR_n = 1'b1;
		A = '0;
		DO = '0;
		KD = 7'($random(seed));
		CASIN = 1'b1;
		joystick_0 = $random(seed);
		joystick_1 = $random(seed);
		img_size = $random(seed);
		img_mounted = 1'b1;
		for (int i = 0; i < 65536; i++)
			ram_model[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
		repeat (16) @(posedge F14M);
		#DRIVE_DELAY;
		expect_equal({CPUENA, sdram_wr, sdram_rd, BUZZER, CASOUT}, 5'b00000,
			"outputs during reset");
		RESET = 1'b0;
		measure_sync();
		check_read_strobe();
		exercise_banks();
		probe_mapped_io();
		read_ports();
		inspect_pixels();
		$display("test passed");
		$finish;
	end

endmodule

// ==== sim.f ====
logic/vtl_pkg.sv
logic/raster_timing.sv
logic/cpu_beat.sv
logic/port_registers.sv
logic/sdram_slots.sv
logic/gr5_pixel_out.sv
logic/vtl_video_chip.sv
sim/tb_vtl.sv
